// File: testbench/rob_stim.txt
# op f1 f2 f3 f4 in hex: A pc rd type - | C port(0 alu 1 mem 2 mul) idx word exc
# S level | Q reg hit value | F full | I cycles | D drain | T code pc addr
A 1000 1 0 0
A 1004 2 1 0
A 1008 3 3 0
C 2 2 33 0
C 1 1 22 0
Q 3 1 33 0
Q 1 0 0 0
Q 0 0 0 0
C 0 0 11 0
D 0 0 0 0
I 2 0 0 0
A 100c 5 0 0
A 1010 5 1 0
S 1 0 0 0
C 0 3 aaaa 0
C 1 4 bbbb 0
Q 5 1 bbbb 0
I 3 0 0 0
S 0 0 0 0
D 0 0 0 0
A 2000 1 1 0
A 2004 2 0 0
A 2008 3 0 0
A 200c 4 3 0
A 2010 5 0 0
A 2014 6 2 0
A 2018 7 0 0
A 201c 8 0 0
A 2020 9 1 0
A 2024 a 0 0
F 1 0 0 0
A 3000 b 0 0
F 1 0 0 0
C 0 6 55 0
C 1 5 12345abc 2
T 2 2000 12345abc 0
A 4000 7 0 0
C 2 0 77 0
D 0 0 0 0

// File: project.f
src/rob_pkg.sv
src/rob_pointers.sv
src/rob_entries.sv
src/rob_bypass.sv
src/rob_commit_ctrl.sv
src/rob_top.sv
testbench/rob_assert.sv
testbench/rob_tb.sv

// File: Bender.yml
package:
  name: rob

sources:
  - src/rob_pkg.sv
  - src/rob_pointers.sv
  - src/rob_entries.sv
  - src/rob_bypass.sv
  - src/rob_commit_ctrl.sv
  - src/rob_top.sv
  - target: simulation
    files:
      - testbench/rob_assert.sv
      - testbench/rob_tb.sv

// File: testbench/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rob_tb;
    import rob_pkg::*;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    stall;
    logic                    alloc;
    logic [XLEN-1:0]         alloc_pc;
    logic [REG_W-1:0]        alloc_rd;
    logic [INSTR_TYPE_W-1:0] alloc_type;
    logic                    alu_done, mem_done, mul_done;
    logic [ROB_IDX_W-1:0]    alu_idx, mem_idx, mul_idx;
    rob_word_u               alu_word, mem_word, mul_word;
    logic [EXC_W-1:0]        alu_exc, mem_exc, mul_exc;
    logic [REG_W-1:0]        rs1, rs2;
    logic [ROB_IDX_W-1:0]    alloc_idx;
    logic                    full, rs1_hit, rs2_hit;
    logic [XLEN-1:0]         rs1_value, rs2_value;
    logic                    commit_valid, exc_valid;
    logic [XLEN-1:0]         commit_value, exc_pc, exc_addr;
    logic [REG_W-1:0]        commit_rd;
    logic [INSTR_TYPE_W-1:0] commit_type;
    logic [ROB_IDX_W-1:0]    commit_idx;
    logic [EXC_W-1:0]        exc_code;

    // Reference model holding entries by index plus allocation order
    logic [XLEN-1:0]         m_pc   [ROB_SIZE];
    logic [REG_W-1:0]        m_rd   [ROB_SIZE];
    logic [INSTR_TYPE_W-1:0] m_type [ROB_SIZE];
    rob_word_u               m_word [ROB_SIZE];
    logic [EXC_W-1:0]        m_exc  [ROB_SIZE];
    int                      order_q[$];
    int                      m_tail = 0;
    logic                    stall_prev = 1'b0;
    logic                    trap_armed = 1'b0;
    int                      mon_idx;

    localparam int WAIT_LIMIT = 60;

    always #10 clk = ~clk;

    rob_top i_dut (.*);

    task automatic fail_run();
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input rob_word_u got, input rob_word_u exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_W-1:0] got,
                             input logic [REG_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_exc(input string name, input logic [EXC_W-1:0] got,
                             input logic [EXC_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_type(input string name, input logic [INSTR_TYPE_W-1:0] got,
                              input logic [INSTR_TYPE_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_idx(input string name, input logic [ROB_IDX_W-1:0] got,
                             input logic [ROB_IDX_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_hit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    // One cycle with all strobes dropped
    task automatic step();
        @(posedge clk);
        alloc    <= 1'b0;
        alu_done <= 1'b0;
        mem_done <= 1'b0;
        mul_done <= 1'b0;
    endtask

    // Commit monitor on pre-edge values
    always @(posedge clk) begin
        if (!reset) begin
            if (i_dut.i_assert.error_count != 0) begin
                $display("The bound assertion checker reported a failure");
                fail_run();
            end
            if (commit_valid) begin
                if (stall_prev) begin
                    $display("Commit seen although stall was high at the retire edge");
                    fail_run();
                end
                if (order_q.size() == 0) begin
                    $display("Commit seen with no entry pending in the model");
                    fail_run();
                end
                mon_idx = order_q.pop_front();
                check_idx("commit_idx", commit_idx, mon_idx);
                check_word("commit_value", commit_value, m_word[mon_idx]);
                check_reg("commit_rd", commit_rd, m_rd[mon_idx]);
                check_type("commit_type", commit_type, m_type[mon_idx]);
            end
            if (exc_valid && !trap_armed) begin
                $display("Unexpected trap reported");
                fail_run();
            end
        end
        stall_prev = stall;
    end

    task automatic drain_queue();
        int cycles;
        cycles = 0;
        while (order_q.size() != 0) begin
            step();
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout waiting for pending entries to commit");
                fail_run();
            end
        end
    endtask

    task automatic expect_trap(input logic [31:0] code, input logic [31:0] pc,
                               input logic [31:0] addr);
        int        cycles;
        int        front;
        rob_word_u exp_addr;
        cycles = 0;
        trap_armed = 1'b1;
        step();
        #1;
        while (!exc_valid) begin
            step();
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout waiting for exc_valid");
                fail_run();
            end
        end
        front = order_q[0];
        // The completion word of a faulting entry is its address
        exp_addr = m_word[front];
        check_exc("exc_code", exc_code, m_exc[front]);
        check_exc("exc_code", exc_code, code[EXC_W-1:0]);
        check_word("exc_pc", exc_pc, m_pc[front]);
        check_word("exc_pc", exc_pc, pc);
        check_word("exc_addr", exc_addr, exp_addr);
        check_word("exc_addr", exc_addr, addr);
        // Younger entries are discarded
        order_q.delete();
        m_tail = 0;
        step();
        #1;
        check_idx("alloc_idx", alloc_idx, '0);
        check_hit("full", full, 1'b0);
        trap_armed = 1'b0;
    endtask

    task automatic run_op(input string op, input logic [31:0] f1, input logic [31:0] f2,
                          input logic [31:0] f3, input logic [31:0] f4);
        case (op)
            "A": begin
                step();
                alloc      <= 1'b1;
                alloc_pc   <= f1;
                alloc_rd   <= f2[REG_W-1:0];
                alloc_type <= f3[INSTR_TYPE_W-1:0];
                #1;
                check_idx("alloc_idx", alloc_idx, m_tail[ROB_IDX_W-1:0]);
                // Taken at the next edge unless the model is full or stalled
                if (order_q.size() < ROB_SIZE && !stall) begin
                    m_pc[m_tail]   = f1;
                    m_rd[m_tail]   = f2[REG_W-1:0];
                    m_type[m_tail] = f3[INSTR_TYPE_W-1:0];
                    m_exc[m_tail]  = EXC_NONE;
                    order_q.push_back(m_tail);
                    m_tail = (m_tail == ROB_SIZE - 1) ? 0 : m_tail + 1;
                end
            end
            "C": begin
                step();
                case (f1)
                    0: begin
                        alu_done <= 1'b1;
                        alu_idx  <= f2[ROB_IDX_W-1:0];
                        alu_word <= f3;
                        alu_exc  <= f4[EXC_W-1:0];
                    end
                    1: begin
                        mem_done <= 1'b1;
                        mem_idx  <= f2[ROB_IDX_W-1:0];
                        mem_word <= f3;
                        mem_exc  <= f4[EXC_W-1:0];
                    end
                    default: begin
                        mul_done <= 1'b1;
                        mul_idx  <= f2[ROB_IDX_W-1:0];
                        mul_word <= f3;
                        mul_exc  <= f4[EXC_W-1:0];
                    end
                endcase
                m_word[f2] = f3;
                m_exc[f2]  = f4[EXC_W-1:0];
            end
            "S": begin
                step();
                stall <= f1[0];
            end
            "Q": begin
                step();
                rs1 <= f1[REG_W-1:0];
                rs2 <= f1[REG_W-1:0];
                #1;
                check_hit("rs1_hit", rs1_hit, f2[0]);
                check_hit("rs2_hit", rs2_hit, f2[0]);
                if (f2[0]) begin
                    check_word("rs1_value", rs1_value, f3);
                    check_word("rs2_value", rs2_value, f3);
                end
            end
            "F": begin
                step();
                #1;
                check_hit("full", full, f1[0]);
            end
            "I": repeat (f1 + $urandom % 3) step();
            "D": drain_queue();
            "T": expect_trap(f1, f2, f3);
            default: begin
                $display("Unknown operation in stimulus file: %s", op);
                fail_run();
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          n;
        int          seed_val;
        string       line;
        string       op;
        logic [31:0] f1, f2, f3, f4;

        seed_val = $urandom(32);
        reset = 1'b1;
        stall = 1'b0;
        alloc = 1'b0;
        alloc_pc = '0;
        alloc_rd = '0;
        alloc_type = '0;
        {alu_done, mem_done, mul_done} = '0;
        {alu_idx, mem_idx, mul_idx} = '0;
        {alu_word, mem_word, mul_word} = '0;
        {alu_exc, mem_exc, mul_exc} = '0;
        rs1 = '0;
        rs2 = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        #1;
        check_hit("commit_valid", commit_valid, 1'b0);
        check_hit("exc_valid", exc_valid, 1'b0);
        check_hit("full", full, 1'b0);
        check_idx("alloc_idx", alloc_idx, '0);

        fd = $fopen("testbench/rob_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            fail_run();
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != 8'h23) begin
                n = $sscanf(line, "%s %h %h %h %h", op, f1, f2, f3, f4);
                if (n == 5) begin
                    run_op(op, f1, f2, f3, f4);
                end
            end
        end
        $fclose(fd);
        drain_queue();
        if (i_dut.i_assert.error_count != 0) begin
            $display("The bound assertion checker reported a failure");
            fail_run();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: testbench/rob_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rob_assert (
    input logic                          clk,
    input logic                          reset,
    input logic [rob_pkg::ROB_SIZE-1:0]  valid_vec,
    input logic                          full,
    input logic                          commit_valid,
    input logic                          exc_valid,
    input logic [rob_pkg::ROB_IDX_W-1:0] alloc_idx
);

    // Failed property count
    int error_count = 0;

    // Every entry in use must block decode
    a_full_when_all_valid: assert property (@(posedge clk) disable iff (reset)
        (&valid_vec) |-> full)
        else begin
            error_count++;
            $error("full low with every entry valid");
        end

    // Nothing commits with the trap or during the flush cycle after it
    a_no_commit_on_trap: assert property (@(posedge clk) disable iff (reset)
        exc_valid |-> !commit_valid ##1 !commit_valid)
        else begin
            error_count++;
            $error("commit_valid high with or right after exc_valid");
        end

    // Tail back at zero once the flush edge has passed
    a_flush_resets_tail: assert property (@(posedge clk) disable iff (reset)
        exc_valid |-> ##1 (alloc_idx == '0))
        else begin
            error_count++;
            $error("alloc_idx not zero after trap flush");
        end

endmodule

bind rob_top rob_assert i_assert (
    .clk(clk), .reset(reset), .valid_vec(valid_vec), .full(full),
    .commit_valid(commit_valid), .exc_valid(exc_valid), .alloc_idx(alloc_idx)
);

`default_nettype wire

// File: src/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             stall,
    input  logic                             alloc,
    input  logic [rob_pkg::XLEN-1:0]         alloc_pc,
    input  logic [rob_pkg::REG_W-1:0]        alloc_rd,
    input  logic [rob_pkg::INSTR_TYPE_W-1:0] alloc_type,
    input  logic                             alu_done,
    input  logic [rob_pkg::ROB_IDX_W-1:0]    alu_idx,
    input  rob_pkg::rob_word_u               alu_word,
    input  logic [rob_pkg::EXC_W-1:0]        alu_exc,
    input  logic                             mem_done,
    input  logic [rob_pkg::ROB_IDX_W-1:0]    mem_idx,
    input  rob_pkg::rob_word_u               mem_word,
    input  logic [rob_pkg::EXC_W-1:0]        mem_exc,
    input  logic                             mul_done,
    input  logic [rob_pkg::ROB_IDX_W-1:0]    mul_idx,
    input  rob_pkg::rob_word_u               mul_word,
    input  logic [rob_pkg::EXC_W-1:0]        mul_exc,
    input  logic [rob_pkg::REG_W-1:0]        rs1,
    input  logic [rob_pkg::REG_W-1:0]        rs2,
    output logic [rob_pkg::ROB_IDX_W-1:0]    alloc_idx,
    output logic                             full,
    output logic                             rs1_hit,
    output logic [rob_pkg::XLEN-1:0]         rs1_value,
    output logic                             rs2_hit,
    output logic [rob_pkg::XLEN-1:0]         rs2_value,
    output logic                             commit_valid,
    output logic [rob_pkg::XLEN-1:0]         commit_value,
    output logic [rob_pkg::REG_W-1:0]        commit_rd,
    output logic [rob_pkg::INSTR_TYPE_W-1:0] commit_type,
    output logic [rob_pkg::ROB_IDX_W-1:0]    commit_idx,
    output logic                             exc_valid,
    output logic [rob_pkg::EXC_W-1:0]        exc_code,
    output logic [rob_pkg::XLEN-1:0]         exc_pc,
    output logic [rob_pkg::XLEN-1:0]         exc_addr
);
    import rob_pkg::*;

    logic                    alloc_en;
    logic                    retire;
    logic                    flush;
    logic                    flushing;
    logic                    ptr_full;
    logic [ROB_IDX_W-1:0]    head_idx;
    logic [ROB_CNT_W-1:0]    count;
    logic                    head_valid;
    logic                    head_complete;
    logic [EXC_W-1:0]        head_exc;
    logic [XLEN-1:0]         head_pc;
    logic [REG_W-1:0]        head_rd;
    logic [INSTR_TYPE_W-1:0] head_type;
    rob_word_u               head_word;
    logic [ROB_SIZE-1:0]     valid_vec;
    logic [ROB_SIZE-1:0]     complete_vec;
    logic [ROB_SIZE*EXC_W-1:0] exc_vec;
    logic [ROB_SIZE*REG_W-1:0] rd_vec;
    logic [ROB_SIZE*XLEN-1:0]  word_vec;

    // No new entries while the trap flush is pending
    assign full     = ptr_full || flushing;
    assign alloc_en = alloc && !full && !stall;

    rob_pointers i_pointers (
        .clk(clk), .reset(reset), .alloc_en(alloc_en), .retire(retire), .flush(flush),
        .head_idx(head_idx), .alloc_idx(alloc_idx), .count(count), .full(ptr_full)
    );

    rob_entries i_entries (
        .clk(clk), .reset(reset), .alloc_en(alloc_en), .alloc_idx(alloc_idx),
        .alloc_pc(alloc_pc), .alloc_rd(alloc_rd), .alloc_type(alloc_type),
        .alu_done(alu_done), .alu_idx(alu_idx), .alu_word(alu_word), .alu_exc(alu_exc),
        .mem_done(mem_done), .mem_idx(mem_idx), .mem_word(mem_word), .mem_exc(mem_exc),
        .mul_done(mul_done), .mul_idx(mul_idx), .mul_word(mul_word), .mul_exc(mul_exc),
        .retire(retire), .flush(flush), .head_idx(head_idx),
        .head_valid(head_valid), .head_complete(head_complete), .head_exc(head_exc),
        .head_pc(head_pc), .head_rd(head_rd), .head_type(head_type), .head_word(head_word),
        .valid_vec(valid_vec), .complete_vec(complete_vec), .exc_vec(exc_vec),
        .rd_vec(rd_vec), .word_vec(word_vec)
    );

    rob_bypass i_bypass (
        .head_idx(head_idx), .alloc_idx(alloc_idx), .count(count),
        .valid_vec(valid_vec), .complete_vec(complete_vec), .exc_vec(exc_vec),
        .rd_vec(rd_vec), .word_vec(word_vec), .rs1(rs1), .rs2(rs2),
        .rs1_hit(rs1_hit), .rs1_value(rs1_value), .rs2_hit(rs2_hit), .rs2_value(rs2_value)
    );

    rob_commit_ctrl i_commit_ctrl (
        .clk(clk), .reset(reset), .stall(stall),
        .head_valid(head_valid), .head_complete(head_complete), .head_exc(head_exc),
        .head_pc(head_pc), .head_rd(head_rd), .head_type(head_type),
        .head_word(head_word), .head_idx(head_idx),
        .retire(retire), .flush(flush), .flushing(flushing),
        .commit_valid(commit_valid), .commit_value(commit_value), .commit_rd(commit_rd),
        .commit_type(commit_type), .commit_idx(commit_idx),
        .exc_valid(exc_valid), .exc_code(exc_code), .exc_pc(exc_pc), .exc_addr(exc_addr)
    );

endmodule

`default_nettype wire

// File: src/rob_commit_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rob_commit_ctrl (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             stall,
    input  logic                             head_valid,
    input  logic                             head_complete,
    input  logic [rob_pkg::EXC_W-1:0]        head_exc,
    input  logic [rob_pkg::XLEN-1:0]         head_pc,
    input  logic [rob_pkg::REG_W-1:0]        head_rd,
    input  logic [rob_pkg::INSTR_TYPE_W-1:0] head_type,
    input  rob_pkg::rob_word_u               head_word,
    input  logic [rob_pkg::ROB_IDX_W-1:0]    head_idx,
    output logic                             retire,
    output logic                             flush,
    output logic                             flushing,
    output logic                             commit_valid,
    output logic [rob_pkg::XLEN-1:0]         commit_value,
    output logic [rob_pkg::REG_W-1:0]        commit_rd,
    output logic [rob_pkg::INSTR_TYPE_W-1:0] commit_type,
    output logic [rob_pkg::ROB_IDX_W-1:0]    commit_idx,
    output logic                             exc_valid,
    output logic [rob_pkg::EXC_W-1:0]        exc_code,
    output logic [rob_pkg::XLEN-1:0]         exc_pc,
    output logic [rob_pkg::XLEN-1:0]         exc_addr
);
    import rob_pkg::*;

    logic state;
    logic head_ready;
    logic trap;

    // Head is done and the pipe is moving
    assign head_ready = (state == ROB_ST_RUN) && !stall && head_valid && head_complete;
    assign retire     = head_ready && (head_exc == EXC_NONE);
    assign trap       = head_ready && (head_exc != EXC_NONE);
    assign flush      = (state == ROB_ST_FLUSH);
    assign flushing   = (state == ROB_ST_FLUSH);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ROB_ST_RUN;
        end else if (trap) begin
            state <= ROB_ST_FLUSH;
        end else if (state == ROB_ST_FLUSH) begin
            state <= ROB_ST_RUN;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            exc_valid    <= 1'b0;
        end else begin
            commit_valid <= retire;
            exc_valid    <= trap;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit_value <= head_word.result;
            commit_rd    <= head_rd;
            commit_type  <= head_type;
            commit_idx   <= head_idx;
        end
        // Same word read as a faulting address
        if (trap) begin
            exc_code <= head_exc;
            exc_pc   <= head_pc;
            exc_addr <= {head_word.fault.page, head_word.fault.offset};
        end
    end

endmodule

`default_nettype wire

// File: src/rob_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module rob_bypass (
    input  logic [rob_pkg::ROB_IDX_W-1:0]               head_idx,
    input  logic [rob_pkg::ROB_IDX_W-1:0]               alloc_idx,
    input  logic [rob_pkg::ROB_CNT_W-1:0]               count,
    input  logic [rob_pkg::ROB_SIZE-1:0]                valid_vec,
    input  logic [rob_pkg::ROB_SIZE-1:0]                complete_vec,
    input  logic [rob_pkg::ROB_SIZE*rob_pkg::EXC_W-1:0] exc_vec,
    input  logic [rob_pkg::ROB_SIZE*rob_pkg::REG_W-1:0] rd_vec,
    input  logic [rob_pkg::ROB_SIZE*rob_pkg::XLEN-1:0]  word_vec,
    input  logic [rob_pkg::REG_W-1:0]                   rs1,
    input  logic [rob_pkg::REG_W-1:0]                   rs2,
    output logic                                        rs1_hit,
    output logic [rob_pkg::XLEN-1:0]                    rs1_value,
    output logic                                        rs2_hit,
    output logic [rob_pkg::XLEN-1:0]                    rs2_value
);
    import rob_pkg::*;

    always_comb begin
        int   pos;
        int   age;
        logic usable;

        rs1_hit   = 1'b0;
        rs1_value = '0;
        rs2_hit   = 1'b0;
        rs2_value = '0;
        // k = 0 is the youngest entry, one behind the tail
        for (int k = 0; k < ROB_SIZE; k++) begin
            pos = int'(alloc_idx) + ROB_SIZE - 1 - k;
            if (pos >= ROB_SIZE) begin
                pos = pos - ROB_SIZE;
            end
            // Distance from head, count separates full from empty
            age = pos - int'(head_idx);
            if (age < 0) begin
                age = age + ROB_SIZE;
            end
            usable = (age < int'(count)) && valid_vec[pos] && complete_vec[pos] &&
                     (exc_vec[pos*EXC_W +: EXC_W] == EXC_NONE);
            if (usable && !rs1_hit && rs1 != '0 && rd_vec[pos*REG_W +: REG_W] == rs1) begin
                rs1_hit   = 1'b1;
                rs1_value = word_vec[pos*XLEN +: XLEN];
            end
            if (usable && !rs2_hit && rs2 != '0 && rd_vec[pos*REG_W +: REG_W] == rs2) begin
                rs2_hit   = 1'b1;
                rs2_value = word_vec[pos*XLEN +: XLEN];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/rob_entries.sv
`timescale 1ns/1ps
`default_nettype none

module rob_entries (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     alloc_en,
    input  logic [rob_pkg::ROB_IDX_W-1:0]            alloc_idx,
    input  logic [rob_pkg::XLEN-1:0]                 alloc_pc,
    input  logic [rob_pkg::REG_W-1:0]                alloc_rd,
    input  logic [rob_pkg::INSTR_TYPE_W-1:0]         alloc_type,
    input  logic                                     alu_done,
    input  logic [rob_pkg::ROB_IDX_W-1:0]            alu_idx,
    input  rob_pkg::rob_word_u                       alu_word,
    input  logic [rob_pkg::EXC_W-1:0]                alu_exc,
    input  logic                                     mem_done,
    input  logic [rob_pkg::ROB_IDX_W-1:0]            mem_idx,
    input  rob_pkg::rob_word_u                       mem_word,
    input  logic [rob_pkg::EXC_W-1:0]                mem_exc,
    input  logic                                     mul_done,
    input  logic [rob_pkg::ROB_IDX_W-1:0]            mul_idx,
    input  rob_pkg::rob_word_u                       mul_word,
    input  logic [rob_pkg::EXC_W-1:0]                mul_exc,
    input  logic                                     retire,
    input  logic                                     flush,
    input  logic [rob_pkg::ROB_IDX_W-1:0]            head_idx,
    output logic                                     head_valid,
    output logic                                     head_complete,
    output logic [rob_pkg::EXC_W-1:0]                head_exc,
    output logic [rob_pkg::XLEN-1:0]                 head_pc,
    output logic [rob_pkg::REG_W-1:0]                head_rd,
    output logic [rob_pkg::INSTR_TYPE_W-1:0]         head_type,
    output rob_pkg::rob_word_u                       head_word,
    output logic [rob_pkg::ROB_SIZE-1:0]             valid_vec,
    output logic [rob_pkg::ROB_SIZE-1:0]             complete_vec,
    output logic [rob_pkg::ROB_SIZE*rob_pkg::EXC_W-1:0] exc_vec,
    output logic [rob_pkg::ROB_SIZE*rob_pkg::REG_W-1:0] rd_vec,
    output logic [rob_pkg::ROB_SIZE*rob_pkg::XLEN-1:0]  word_vec
);
    import rob_pkg::*;

    logic [XLEN-1:0]         pc_mem   [ROB_SIZE];
    logic [REG_W-1:0]        rd_mem   [ROB_SIZE];
    logic [INSTR_TYPE_W-1:0] type_mem [ROB_SIZE];
    logic [EXC_W-1:0]        exc_mem  [ROB_SIZE];
    rob_word_u               word_mem [ROB_SIZE];

    // Status bits
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_vec    <= '0;
            complete_vec <= '0;
        end else begin
            if (retire) begin
                valid_vec[head_idx]    <= 1'b0;
                complete_vec[head_idx] <= 1'b0;
            end
            if (alloc_en) begin
                valid_vec[alloc_idx]    <= 1'b1;
                complete_vec[alloc_idx] <= 1'b0;
            end
            // Completions land even while stalled
            if (alu_done) begin
                complete_vec[alu_idx] <= 1'b1;
            end
            if (mem_done) begin
                complete_vec[mem_idx] <= 1'b1;
            end
            if (mul_done) begin
                complete_vec[mul_idx] <= 1'b1;
            end
        end
    end

    // Payload, later writes win so mul beats mem beats alu
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            pc_mem[alloc_idx]   <= alloc_pc;
            rd_mem[alloc_idx]   <= alloc_rd;
            type_mem[alloc_idx] <= alloc_type;
            exc_mem[alloc_idx]  <= EXC_NONE;
        end
        if (alu_done) begin
            word_mem[alu_idx] <= alu_word;
            exc_mem[alu_idx]  <= alu_exc;
        end
        if (mem_done) begin
            word_mem[mem_idx] <= mem_word;
            exc_mem[mem_idx]  <= mem_exc;
        end
        if (mul_done) begin
            word_mem[mul_idx] <= mul_word;
            exc_mem[mul_idx]  <= mul_exc;
        end
    end

    // Head entry read
    assign head_valid    = valid_vec[head_idx];
    assign head_complete = complete_vec[head_idx];
    assign head_exc      = exc_mem[head_idx];
    assign head_pc       = pc_mem[head_idx];
    assign head_rd       = rd_mem[head_idx];
    assign head_type     = type_mem[head_idx];
    assign head_word     = word_mem[head_idx];

    // Flattened views for the bypass search
    always_comb begin
        for (int i = 0; i < ROB_SIZE; i++) begin
            exc_vec[i*EXC_W +: EXC_W]  = exc_mem[i];
            rd_vec[i*REG_W +: REG_W]   = rd_mem[i];
            word_vec[i*XLEN +: XLEN]   = word_mem[i].result;
        end
    end

endmodule

`default_nettype wire

// File: src/rob_pointers.sv
`timescale 1ns/1ps
`default_nettype none

module rob_pointers (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          alloc_en,
    input  logic                          retire,
    input  logic                          flush,
    output logic [rob_pkg::ROB_IDX_W-1:0] head_idx,
    output logic [rob_pkg::ROB_IDX_W-1:0] alloc_idx,
    output logic [rob_pkg::ROB_CNT_W-1:0] count,
    output logic                          full
);
    import rob_pkg::*;

    localparam logic [ROB_IDX_W-1:0] LAST_IDX = ROB_IDX_W'(ROB_SIZE - 1);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head_idx  <= '0;
            alloc_idx <= '0;
            count     <= '0;
        end else begin
            if (retire) begin
                head_idx <= (head_idx == LAST_IDX) ? '0 : head_idx + 1'b1;
            end
            if (alloc_en) begin
                alloc_idx <= (alloc_idx == LAST_IDX) ? '0 : alloc_idx + 1'b1;
            end
            // Alloc and retire together leave the count unchanged
            case ({alloc_en, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full = (count == ROB_CNT_W'(ROB_SIZE));

endmodule

`default_nettype wire

// File: src/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // Buffer geometry
    localparam int ROB_SIZE  = 10;
    localparam int ROB_IDX_W = 4;
    localparam int ROB_CNT_W = 4;

    // Datapath widths
    localparam int XLEN       = 32;
    localparam int REG_W      = 5;
    localparam int PAGE_OFF_W = 12;

    // Instruction classes
    localparam int INSTR_TYPE_W = 3;
    localparam logic [INSTR_TYPE_W-1:0] INSTR_TYPE_ALU   = 3'd0;
    localparam logic [INSTR_TYPE_W-1:0] INSTR_TYPE_LOAD  = 3'd1;
    localparam logic [INSTR_TYPE_W-1:0] INSTR_TYPE_STORE = 3'd2;
    localparam logic [INSTR_TYPE_W-1:0] INSTR_TYPE_MUL   = 3'd3;

    // Exception codes, zero means clean completion
    localparam int EXC_W = 3;
    localparam logic [EXC_W-1:0] EXC_NONE        = 3'd0;
    localparam logic [EXC_W-1:0] EXC_ILLEGAL     = 3'd1;
    localparam logic [EXC_W-1:0] EXC_LOAD_FAULT  = 3'd2;
    localparam logic [EXC_W-1:0] EXC_STORE_FAULT = 3'd3;
    localparam logic [EXC_W-1:0] EXC_MISALIGNED  = 3'd4;

    // Commit controller states
    localparam logic ROB_ST_RUN   = 1'b0;
    localparam logic ROB_ST_FLUSH = 1'b1;

    // Completion word: a result, or the faulting address when exc is set
    typedef union packed {
        logic [XLEN-1:0] result;
        struct packed {
            logic [XLEN-PAGE_OFF_W-1:0] page;
            logic [PAGE_OFF_W-1:0]      offset;
        } fault;
    } rob_word_u;

endpackage

`default_nettype wire
